// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

rm -f sim.log

verilator --binary --timing --timescale 1ns/100ps -f vlog.f \
    --top-module tb_dcache -o tb_dcache_sim > build.log 2>&1 \
    && ./obj_dir/tb_dcache_sim > sim.log 2>&1 \
    || echo "run.sh: build or simulation did not finish cleanly"

grep -qx "Simulation PASSED" sim.log \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail, see build.log and sim.log"; exit 1; }

// File: source/cache_addr_pkg.sv
`include "cache_defines.svh"

package cache_addr_pkg;

    // physical address as the arrays see it
    typedef struct packed {
        logic [`DC_TAG_W-1:0]                      tag;
        logic [`DC_INDEX_W-1:0]                    index;
        logic [$clog2(`DC_WORDS)-1:0]              word;   // word in line
        logic [`DC_OFFSET_W-$clog2(`DC_WORDS)-1:0] bsel;   // byte in word
    } dc_addr_t;

    // raw word for the memory port, fields for indexing
    typedef union packed {
        logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0] raw;
        dc_addr_t                                      fld;
    } dc_addr_u;

    // cpu load/store request
    typedef struct packed {
        logic                    valid;
        logic                    write;  // 1 store, 0 load
        dc_addr_u                addr;
        logic [`DC_DATA_W/8-1:0] wsel;   // store byte mask
        logic [`DC_DATA_W-1:0]   wdata;
    } dc_req_t;

endpackage

// File: source/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// data cache geometry
//////////////////////////////////////////////////////////////////////

// cpu word
`define DC_DATA_W 32

// address split, tag + index + offset = 32
`define DC_TAG_W 20
`define DC_INDEX_W 8
`define DC_OFFSET_W 4

// 16 byte lines
`define DC_WORDS 4

`define DC_SETS 256 // two ways each

`endif

// File: source/cache_mem_pkg.sv
`include "cache_defines.svh"

package cache_mem_pkg;

    typedef logic [`DC_WORDS-1:0][`DC_DATA_W-1:0] dc_line_t;

    // one way as read at an index
    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
        dc_line_t             line;
    } dc_entry_t;

    // write into one way
    typedef struct packed {
        logic [`DC_INDEX_W-1:0]              index;
        logic [`DC_TAG_W-1:0]                tag;
        logic [`DC_WORDS-1:0]                wen;    // bank enables
        logic [`DC_WORDS*`DC_DATA_W/8-1:0]   ben;    // byte enables over line
        dc_line_t                            line;
    } dc_way_wr_t;

    // refill read, level until ret_valid
    typedef struct packed {
        logic                                          req;
        logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0] addr;
    } dc_mem_rd_t;

    typedef struct packed {
        logic                                          strobe; // single cycle
        logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0] addr;
        dc_line_t                                      line;
    } dc_mem_wr_t;

endpackage

// File: source/dcache_lookup_stage.sv
`include "cache_defines.svh"

module dcache_lookup_stage
    import cache_addr_pkg::*;
    import cache_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  dc_req_t               stage_req_i,
    input  dc_entry_t             entry0_i,
    input  dc_entry_t             entry1_i,
    input  logic                  victim_way_i,
    input  logic                  victim_dirty_i,
    input  logic                  ret_valid_i,
    input  dc_line_t              ret_data_i,
    output dc_way_wr_t            way0_wr_o,
    output dc_way_wr_t            way1_wr_o,
    output logic                  hit_o,
    output logic                  hit_way_o,
    output logic                  refill_o,
    output logic                  stall_o,
    output logic                  data_ok_o,
    output logic [`DC_DATA_W-1:0] rdata_o,
    output dc_mem_rd_t            mem_rd_o,
    output dc_mem_wr_t            mem_wr_o
);

    localparam int   BYTES     = `DC_DATA_W / 8;
    localparam logic ST_LOOKUP = 1'b0;
    localparam logic ST_REFILL = 1'b1;  // victim written back, line requested

    logic       state_q;
    dc_addr_t   req_addr;
    logic       hit0;
    logic       hit1;
    logic       hit;
    logic       miss;
    logic       wb_strobe;
    logic       rd_req;
    logic       refill;
    dc_line_t   hit_line;
    dc_line_t   fill_line;
    dc_entry_t  victim_entry;
    dc_addr_u   wb_addr;
    dc_addr_u   fill_addr;
    dc_way_wr_t wr;

    assign req_addr = stage_req_i.addr.fld;

    //////////////////////////////////////////////////////////////////////
    // tag compare
    //////////////////////////////////////////////////////////////////////

    assign hit0 = entry0_i.valid && entry0_i.tag == req_addr.tag;
    assign hit1 = entry1_i.valid && entry1_i.tag == req_addr.tag;
    assign hit  = stage_req_i.valid && (hit0 || hit1);
    assign miss = stage_req_i.valid && !(hit0 || hit1);

    assign hit_line     = hit1 ? entry1_i.line : entry0_i.line;
    assign victim_entry = victim_way_i ? entry1_i : entry0_i;

    //////////////////////////////////////////////////////////////////////
    // miss sequence: write-back, request, refill
    //////////////////////////////////////////////////////////////////////

    assign wb_strobe = miss && state_q == ST_LOOKUP && victim_dirty_i;
    assign rd_req    = miss && (state_q == ST_REFILL || !victim_dirty_i);
    assign refill    = rd_req && ret_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_LOOKUP;
        end else if (refill) begin
            state_q <= ST_LOOKUP;
        end else if (wb_strobe) begin
            state_q <= ST_REFILL;
        end
    end

    // store data lands on top of the returned line
    always_comb begin
        fill_line = ret_data_i;
        if (stage_req_i.write) begin
            for (int b = 0; b < BYTES; b++) begin
                if (stage_req_i.wsel[b]) begin
                    fill_line[req_addr.word][8*b +: 8] = stage_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // array writes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        wr       = '0;
        wr.index = req_addr.index;
        wr.tag   = req_addr.tag;
        if (refill) begin
            wr.wen  = '1;
            wr.ben  = '1;
            wr.line = fill_line;
        end else if (hit && stage_req_i.write) begin
            wr.wen[req_addr.word]                 = 1'b1;
            wr.ben[req_addr.word*BYTES +: BYTES]  = stage_req_i.wsel;
            wr.line                               = {`DC_WORDS{stage_req_i.wdata}};
        end
    end

    // refill goes to the victim, a store hit to its own way
    assign way0_wr_o = (refill ? !victim_way_i : hit0) ? wr : '0;
    assign way1_wr_o = (refill ? victim_way_i : hit1) ? wr : '0;

    //////////////////////////////////////////////////////////////////////
    // cpu and memory side
    //////////////////////////////////////////////////////////////////////

    assign hit_o     = hit;
    assign hit_way_o = hit1;
    assign refill_o  = refill;
    assign stall_o   = miss && !refill;
    assign data_ok_o = hit || refill;
    assign rdata_o   = refill ? fill_line[req_addr.word] : hit_line[req_addr.word];

    always_comb begin
        wb_addr            = '0;
        wb_addr.fld.tag    = victim_entry.tag;
        wb_addr.fld.index  = req_addr.index;
        fill_addr          = stage_req_i.addr;
        fill_addr.fld.word = '0;  // line aligned
        fill_addr.fld.bsel = '0;
    end

    assign mem_wr_o.strobe = wb_strobe;
    assign mem_wr_o.addr   = wb_addr.raw;
    assign mem_wr_o.line   = victim_entry.line;

    assign mem_rd_o.req    = rd_req;
    assign mem_rd_o.addr   = fill_addr.raw;

endmodule

// File: source/dcache_replace.sv
`include "cache_defines.svh"

module dcache_replace (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DC_INDEX_W-1:0] index_i,
    input  logic                   hit_i,
    input  logic                   hit_way_i,
    input  logic                   refill_i,
    input  logic                   refill_write_i,  // write flag of stage 2 request
    output logic                   victim_way_o,
    output logic                   victim_dirty_o
);

    logic [`DC_SETS-1:0]      lru_q;    // names the next victim
    logic [`DC_SETS-1:0][1:0] dirty_q;  // per way
    logic                     lru_cur;

    assign lru_cur        = lru_q[index_i];
    assign victim_way_o   = lru_cur;
    assign victim_dirty_o = dirty_q[index_i][lru_cur];

    //////////////////////////////////////////////////////////////////////
    // lru
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (hit_i) begin
            lru_q[index_i] <= ~hit_way_i;  // other way goes next
        end else if (refill_i) begin
            lru_q[index_i] <= ~lru_cur;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // dirty
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty_q <= '0;
        end else if (hit_i && refill_write_i) begin
            dirty_q[index_i][hit_way_i] <= 1'b1;
        end else if (refill_i) begin
            // store miss leaves the new line dirty, load miss clean
            dirty_q[index_i][lru_cur] <= refill_write_i;
        end
    end

endmodule

// File: source/dcache_req_stage.sv
`include "cache_defines.svh"

module dcache_req_stage
    import cache_addr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  dc_req_t                req_i,
    input  logic                   stall_i,
    output dc_req_t                stage_req_o,
    output logic [`DC_INDEX_W-1:0] rd_index_o
);

    dc_req_t req_q;

    //////////////////////////////////////////////////////////////////////
    // stage 1 to stage 2 register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q.valid <= 1'b0;
            req_q.write <= 1'b0;
        end else if (!stall_i) begin
            req_q <= req_i;
        end
    end

    assign stage_req_o = req_q;

    // while a miss waits the arrays keep reading the held set,
    // so the refilled line shows up as soon as the stall drops
    always_comb begin
        if (stall_i) begin
            rd_index_o = req_q.addr.fld.index;
        end else begin
            rd_index_o = req_i.addr.fld.index;
        end
    end

endmodule

// File: source/dcache_top.sv
`include "cache_defines.svh"

module dcache_top
    import cache_addr_pkg::*;
    import cache_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  dc_req_t               req_i,
    output logic                  stall_o,
    output logic                  data_ok_o,
    output logic [`DC_DATA_W-1:0] rdata_o,
    output dc_mem_rd_t            mem_rd_o,
    output dc_mem_wr_t            mem_wr_o,
    input  logic                  ret_valid_i,
    input  dc_line_t              ret_data_i
);

    dc_req_t                stage_req;
    logic [`DC_INDEX_W-1:0] rd_index;
    dc_entry_t              entry0;
    dc_entry_t              entry1;
    dc_way_wr_t             way0_wr;
    dc_way_wr_t             way1_wr;
    logic                   hit;
    logic                   hit_way;
    logic                   refill;
    logic                   victim_way;
    logic                   victim_dirty;

    dcache_req_stage u_req_stage (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .stall_i     (stall_o),
        .stage_req_o (stage_req),
        .rd_index_o  (rd_index)
    );

    dcache_way_store u_way0 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_i       (way0_wr),
        .entry_o    (entry0)
    );

    dcache_way_store u_way1 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_i       (way1_wr),
        .entry_o    (entry1)
    );

    dcache_replace u_replace (
        .clk            (clk),
        .rst            (rst),
        .index_i        (stage_req.addr.fld.index),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .refill_i       (refill),
        .refill_write_i (stage_req.write),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    dcache_lookup_stage u_lookup (
        .clk            (clk),
        .rst            (rst),
        .stage_req_i    (stage_req),
        .entry0_i       (entry0),
        .entry1_i       (entry1),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .ret_valid_i    (ret_valid_i),
        .ret_data_i     (ret_data_i),
        .way0_wr_o      (way0_wr),
        .way1_wr_o      (way1_wr),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .refill_o       (refill),
        .stall_o        (stall_o),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o),
        .mem_rd_o       (mem_rd_o),
        .mem_wr_o       (mem_wr_o)
    );

endmodule

// File: source/dcache_way_store.sv
`include "cache_defines.svh"

module dcache_way_store
    import cache_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DC_INDEX_W-1:0] rd_index_i,
    input  dc_way_wr_t             wr_i,
    output dc_entry_t              entry_o
);

    localparam int BYTES = `DC_DATA_W / 8;

    logic [`DC_SETS-1:0]  valid_q;
    logic [`DC_TAG_W-1:0] tag_mem [`DC_SETS];
    logic                 wr_en;
    logic                 same_index;
    logic                 valid_rd_q;
    logic [`DC_TAG_W-1:0] tag_rd_q;

    assign wr_en      = |wr_i.wen;
    assign same_index = wr_i.index == rd_index_i; // collision with the read

    //////////////////////////////////////////////////////////////////////
    // tag and valid
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_i.index] <= 1'b1;
            end
            valid_rd_q <= (wr_en && same_index) || valid_q[rd_index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_i.index] <= wr_i.tag;
        end
        tag_rd_q <= (wr_en && same_index) ? wr_i.tag : tag_mem[rd_index_i];
    end

    assign entry_o.valid = valid_rd_q;
    assign entry_o.tag   = tag_rd_q;

    //////////////////////////////////////////////////////////////////////
    // data banks, one word each
    //////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < `DC_WORDS; w++) begin : g_bank
        logic [`DC_DATA_W-1:0] bank_mem [`DC_SETS];
        logic [`DC_DATA_W-1:0] rd_word_q;

        always_ff @(posedge clk) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wr_i.wen[w] && wr_i.ben[w*BYTES+b]) begin
                    bank_mem[wr_i.index][8*b +: 8] <= wr_i.line[w][8*b +: 8];
                end
                // written byte wins over the stale array byte
                if (wr_i.wen[w] && wr_i.ben[w*BYTES+b] && same_index) begin
                    rd_word_q[8*b +: 8] <= wr_i.line[w][8*b +: 8];
                end else begin
                    rd_word_q[8*b +: 8] <= bank_mem[rd_index_i][8*b +: 8];
                end
            end
        end

        assign entry_o.line[w] = rd_word_q;
    end

endmodule

// File: test/dcache_checker.sv
module dcache_checker
    import cache_addr_pkg::*;
    import cache_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  dc_req_t    req_i,
    input  logic       stall_i,
    input  logic       data_ok_i,
    input  logic [31:0] rdata_i,
    input  dc_mem_rd_t mem_rd_i,
    input  dc_mem_wr_t mem_wr_i,
    input  logic       ret_valid_i,
    input  dc_line_t   ret_data_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int T_RESET  = 0;
    localparam int T_READ   = 1;
    localparam int T_BYTE   = 2;
    localparam int T_HIT    = 3;
    localparam int T_VICTIM = 4;
    localparam int T_REFILL = 5;
    localparam int N_TESTS  = 6;

    string    test_name [N_TESTS];
    int       checks [N_TESTS];
    int       errors [N_TESTS];
    int       error_total;
    dc_line_t ref_mem [logic [27:0]];       // line address -> content
    bit       partial_word [logic [29:0]];  // words touched by a partial mask

    logic        ref_valid [256][2];
    logic [19:0] ref_tag [256][2];
    logic        ref_dirty [256][2];
    logic        ref_lru [256];

    dc_req_t s_req;  // request in stage 2
    logic    s_valid;
    logic    s_first;
    logic    rd_checked;
    logic    reset_seen;

    initial begin
        test_name = '{"reset", "read_data", "byte_writes", "hit_latency",
                      "victim_writeback", "refill_address"};
        checks      = '{default: 0};
        errors      = '{default: 0};
        error_total = 0;
        reset_seen  = 1'b0;
    end

    task automatic check_val(input int test, input logic [127:0] exp, input logic [127:0] act);
        checks[test]++;
        if (exp !== act) begin
            errors[test]++;
            error_total++;
            $display("** Error: %s: expected %0h, actual %0h", test_name[test], exp, act);
        end
    endtask

    task automatic fail_plain(input int test, input string what);
        checks[test]++;
        errors[test]++;
        error_total++;
        $display("%s: %s", test_name[test], what);
    endtask

    task automatic report();
        for (int t = 0; t < N_TESTS; t++) begin
            $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference cache, stepped on every rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : watch
        logic [7:0]  idx;
        logic [19:0] tag;
        logic [1:0]  word;
        logic [27:0] key;
        logic [27:0] vkey;
        logic        hit;
        logic        hway;
        logic        vway;
        dc_line_t    line;
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                ref_valid[i] = '{1'b0, 1'b0};
                ref_dirty[i] = '{1'b0, 1'b0};
                ref_lru[i]   = 1'b0;
            end
            s_valid    = 1'b0;
            s_first    = 1'b0;
            reset_seen = 1'b1;
        end else begin
            if (reset_seen) begin
                check_val(T_RESET, 128'(4'b0),
                          128'({stall_i, data_ok_i, mem_rd_i.req, mem_wr_i.strobe}));
                reset_seen = 1'b0;
            end
            if (s_valid) begin
                idx  = s_req.addr.fld.index;
                tag  = s_req.addr.fld.tag;
                word = s_req.addr.fld.word;
                key  = {tag, idx};
                hit  = 1'b0;
                hway = 1'b0;
                for (int w = 0; w < 2; w++) begin
                    if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                        hit  = 1'b1;
                        hway = 1'(w);
                    end
                end
                vway = ref_lru[idx];
                vkey = {ref_tag[idx][vway], idx};
                if (s_first) begin
                    if (hit) begin
                        check_val(T_HIT, 128'(1'b1), 128'(data_ok_i));
                        check_val(T_HIT, 128'(2'b0), 128'({mem_rd_i.req, mem_wr_i.strobe}));
                    end else if (ref_dirty[idx][vway]) begin
                        check_val(T_VICTIM, 128'({1'b1, vkey, 4'h0}),
                                  128'({mem_wr_i.strobe, mem_wr_i.addr}));
                        if (ref_mem.exists(vkey)) begin
                            check_val(T_VICTIM, ref_mem[vkey], mem_wr_i.line);
                        end else begin
                            fail_plain(T_VICTIM, "dirty victim has no reference content");
                        end
                        check_val(T_VICTIM, 128'(1'b0), 128'(mem_rd_i.req)); // read comes later
                    end else begin
                        check_val(T_VICTIM, 128'(1'b0), 128'(mem_wr_i.strobe));
                    end
                end else if (mem_wr_i.strobe) begin
                    fail_plain(T_VICTIM, "more than one write-back strobe for one miss");
                end
                if (!hit && mem_rd_i.req && !rd_checked) begin
                    check_val(T_REFILL, 128'({key, 4'h0}), 128'(mem_rd_i.addr));
                    rd_checked = 1'b1;
                end
                if (data_ok_i) begin
                    if (!hit) begin
                        if (!ret_valid_i) begin
                            fail_plain(T_READ, "miss completed without a refill return");
                        end
                        if (!ref_mem.exists(key)) begin
                            ref_mem[key] = ret_data_i;  // first fetch of this line
                        end
                    end
                    line = ref_mem.exists(key) ? ref_mem[key] : '0;
                    if (s_req.write) begin
                        for (int b = 0; b < 4; b++) begin
                            if (s_req.wsel[b]) begin
                                line[word][8*b +: 8] = s_req.wdata[8*b +: 8];
                            end
                        end
                        ref_mem[key] = line;
                        if (s_req.wsel != 4'hf) begin
                            partial_word[{key, word}] = 1'b1;
                        end
                    end else if (partial_word.exists({key, word})) begin
                        check_val(T_BYTE, 128'(line[word]), 128'(rdata_i));
                    end else begin
                        check_val(T_READ, 128'(line[word]), 128'(rdata_i));
                    end
                    if (hit) begin
                        ref_lru[idx] = ~hway;
                        if (s_req.write) begin
                            ref_dirty[idx][hway] = 1'b1;
                        end
                    end else begin
                        ref_valid[idx][vway] = 1'b1;
                        ref_tag[idx][vway]   = tag;
                        ref_dirty[idx][vway] = s_req.write;
                        ref_lru[idx]         = ~vway;
                    end
                    s_valid = 1'b0;
                end
            end else begin
                // empty stage 2 keeps the ports quiet
                if (data_ok_i) begin
                    fail_plain(T_READ, "completion with no request in stage 2");
                end
                if (mem_rd_i.req) begin
                    fail_plain(T_REFILL, "memory read request with no request in stage 2");
                end
                if (mem_wr_i.strobe) begin
                    fail_plain(T_VICTIM, "write-back strobe with no request in stage 2");
                end
            end
            if (!stall_i) begin
                s_req      = req_i;
                s_valid    = req_i.valid;
                s_first    = 1'b1;
                rd_checked = 1'b0;
            end else begin
                s_first = 1'b0;
            end
        end
    end

endmodule

// File: test/tb_dcache.sv
module tb_dcache
    import cache_addr_pkg::*;
    import cache_mem_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQ = 400;
    localparam int LIMIT   = NUM_REQ * 12;

    logic        clk;
    logic        rst;
    dc_req_t     req_i;
    logic        stall_o;
    logic        data_ok_o;
    logic [31:0] rdata_o;
    dc_mem_rd_t  mem_rd_o;
    dc_mem_wr_t  mem_wr_o;
    logic        ret_valid_i;
    dc_line_t    ret_data_i;

    logic [19:0] tag_tbl [4] = '{20'h12345, 20'h0abcd, 20'h7f00e, 20'h00421};
    logic [7:0]  idx_tbl [3] = '{8'h03, 8'h80, 8'hff};

    logic [31:0] rng_stim;
    logic [31:0] rng_mem;
    dc_line_t    store [logic [27:0]];  // responder backing store
    logic [27:0] pend_key;
    logic        busy;
    int          wait_cnt;
    int          issued;
    int          completed;
    int          cycles;
    logic        accepted;

    dcache_top DUT (.*);

    dcache_checker u_chk (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .stall_i     (stall_o),
        .data_ok_i   (data_ok_o),
        .rdata_i     (rdata_o),
        .mem_rd_i    (mem_rd_o),
        .mem_wr_i    (mem_wr_o),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // cpu side stimulus, held while stalled
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        accepted <= req_i.valid && !stall_o;
        if (!rst && data_ok_o) begin
            completed <= completed + 1;
        end
        cycles <= cycles + 1;
    end

    always @(negedge clk) begin
        if (!rst && (!req_i.valid || accepted)) begin
            rng_stim = lcg_step(rng_stim);
            req_i    = '0;
            if (issued < NUM_REQ && rng_stim[31:29] != 3'd0) begin  // some idle cycles
                req_i.valid          = 1'b1;
                req_i.write          = rng_stim[16];
                req_i.addr.fld.tag   = tag_tbl[rng_stim[3:2]];
                req_i.addr.fld.index = idx_tbl[int'(rng_stim[7:4]) % 3];
                req_i.addr.fld.word  = rng_stim[9:8];
                req_i.wsel           = rng_stim[13:10];
                rng_stim             = lcg_step(rng_stim);
                req_i.wdata          = rng_stim;
                issued++;
            end
        end
    end

    // memory responder
    always @(negedge clk) begin
        if (rst) begin
            ret_valid_i = 1'b0;
            busy        = 1'b0;
        end else begin
            if (mem_wr_o.strobe) begin
                store[mem_wr_o.addr[31:4]] = mem_wr_o.line;
            end
            ret_valid_i = 1'b0;
            if (busy) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    ret_valid_i = 1'b1;
                    ret_data_i  = store[pend_key];
                    busy        = 1'b0;
                end
            end else if (mem_rd_o.req) begin
                rng_mem  = lcg_step(rng_mem);
                wait_cnt = 1 + int'(rng_mem[15:8]) % 6;
                pend_key = mem_rd_o.addr[31:4];
                busy     = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (cycles >= LIMIT) begin
            $display("timeout: %0d of %0d requests completed in %0d cycles",
                     completed, NUM_REQ, cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        req_i       = '0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        issued      = 0;
        completed   = 0;
        cycles      = 0;
        busy        = 1'b0;
        wait_cnt    = 0;
        pend_key    = '0;
        rng_stim    = 32'hc5dcb21d;
        rng_mem     = 32'hc5dcb21d;
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 3; i++) begin
                for (int w = 0; w < 4; w++) begin
                    rng_mem = lcg_step(rng_mem);
                    store[{tag_tbl[t], idx_tbl[i]}][w] =
                        rng_mem ^ {tag_tbl[t], idx_tbl[i], 2'(w), 2'b00};
                end
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        wait (completed == NUM_REQ);
        @(negedge clk);
        u_chk.report();
        $display("%0d requests completed, %0d errors", completed, u_chk.error_total);
        if (u_chk.error_total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/cache_addr_pkg.sv
source/cache_mem_pkg.sv
source/dcache_req_stage.sv
source/dcache_way_store.sv
source/dcache_replace.sv
source/dcache_lookup_stage.sv
source/dcache_top.sv
test/dcache_checker.sv
test/tb_dcache.sv
